//--- sim.f
+incdir+hw
hw/core_pkg.sv
hw/adc_unfold.sv
hw/mm_cdr.sv
hw/pi_scaler.sv
hw/prbs_checker.sv
hw/digital_core.sv
dv/tb_clock_gen.sv
dv/tb_digital_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_digital_core -o sim_tb

out="$(./obj_dir/sim_tb 2>&1)" || true
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
    exit 0
else
    exit 1
fi

//--- dv/tb_digital_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module tb_digital_core;
    import core_pkg::*;

    localparam int MAXW = 256;
    localparam int MASK = (1 << `NPI) - 1;

    // kind 0 is a constant word, 1 a PRBS7 stream, 2 PRBS7 with flipped bits
    typedef struct {
        int kind;
        int cycles;
        bit cdr_en;
        bit rnd_pi;
        int off2;
        int pat;
        int n_flip;
        int exp;
    } row_t;

    logic                 clk_adc;
    logic                 reset_i;
    adc_word_t [`NTI-1:0] adc_i;
    core_cfg_t            cfg_i;
    pi_ctl_t              pi_ctl_o;
    logic [`NCNT-1:0]     prbs_correct_o;
    logic [`NCNT-1:0]     prbs_total_o;

    row_t       rows[6];
    int         samp[MAXW][`NTI];
    int         corr[MAXW];
    int         err[MAXW];
    int         pc[MAXW];
    core_cfg_t  cfg_hist[MAXW];
    core_cfg_t  cfg_init;
    logic [6:0] prbs_hist;

    tb_clock_gen u_clk (
        .clk_o   (clk_adc),
        .reset_o (reset_i)
    );

    digital_core u_dut (
        .clk_adc        (clk_adc),
        .reset_i        (reset_i),
        .adc_i          (adc_i),
        .cfg_i          (cfg_i),
        .pi_ctl_o       (pi_ctl_o),
        .prbs_correct_o (prbs_correct_o),
        .prbs_total_o   (prbs_total_o)
    );

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    function automatic int unfold(input adc_word_t w, input sample_t off);
        int v;
        v = w.sign ? int'(w.mag) : -int'(w.mag);
        v = v - int'(off);
        if (v > 127) v = 127;
        if (v < -127) v = -127;
        return v;
    endfunction

    function automatic int sgn(input int x);
        return (x >= 0) ? 1 : -1;
    endfunction

    function automatic int mm_pair(input int p, input int c);
        return c * sgn(p) - p * sgn(c);
    endfunction

    function automatic int sample_at(input int n, input int i);
        return (n < 0) ? 0 : samp[n][i];
    endfunction

    // Bits before the first word come from zero samples
    function automatic bit dec_bit(input int j);
        if (j < 0) return 1'b1;
        return samp[j / `NTI][j % `NTI] >= 0;
    endfunction

    function automatic core_cfg_t cfg_of(input int n);
        return (n < 0) ? cfg_init : cfg_hist[n];
    endfunction

    function automatic int pat_val(input int pat, input int i);
        int vals[4];
        vals = '{20, 100, -20, -100};
        return (pat == 0) ? 60 : vals[i];
    endfunction

    function automatic adc_word_t encode(input int v);
        adc_word_t w;
        w.sign = (v >= 0);
        w.mag  = 8'((v < 0) ? -v : v);
        return w;
    endfunction

    function automatic int pattern_err(input int pat);
        int e;
        e = 0;
        for (int i = 0; i < `NTI; i++) begin
            e = e + mm_pair(pat_val(pat, (i + `NTI - 1) % `NTI), pat_val(pat, i));
        end
        return e;
    endfunction

    function automatic pi_ctl_t scale_ctl(input int code, input core_cfg_t c);
        pi_ctl_t r;
        int      s;
        for (int j = 0; j < `NOUT; j++) begin
            s    = ((code + int'(c.pi_offset[j])) & MASK) * int'(c.pi_scale[j]);
            r[j] = `NPI'(s >> `NPI);
        end
        return r;
    endfunction

    // Reference model of one word through unfold, PD, loop and PRBS check
    task automatic record_word(input int m, input adc_word_t [`NTI-1:0] w, input core_cfg_t c);
        int        j;
        core_cfg_t cp;
        cfg_hist[m] = c;
        for (int i = 0; i < `NTI; i++) samp[m][i] = unfold(w[i], c.lane_offset[i]);
        err[m] = mm_pair(sample_at(m - 1, `NTI - 1), samp[m][0]);
        for (int i = 1; i < `NTI; i++) err[m] = err[m] + mm_pair(samp[m][i-1], samp[m][i]);
        corr[m] = 0;
        for (int i = 0; i < `NTI; i++) begin
            j = `NTI * m + i;
            if (dec_bit(j) == (dec_bit(j - `PRBS_TAP_A) ^ dec_bit(j - `PRBS_TAP_B)))
                corr[m] = corr[m] + 1;
        end
        cp    = cfg_of(m - 1);
        pc[m] = (m > 0) ? pc[m-1] : 0;
        if (cp.cdr_en && m >= 3) pc[m] = (pc[m] + (err[m-3] >>> int'(cp.kp_shift))) & MASK;
    endtask

    task automatic check_outputs(input int m, inout logic [`NCNT-1:0] pc_q,
                                 inout logic [`NCNT-1:0] pt_q);
        pi_ctl_t          exp_ctl;
        logic [`NCNT-1:0] exp_c;
        logic [`NCNT-1:0] exp_t;
        exp_ctl = scale_ctl((m > 0) ? pc[m-1] : 0, cfg_of(m - 1));
        assert (pi_ctl_o == exp_ctl) else
            fail_stop($sformatf("Fail pi_ctl_o: got %h expected %h", pi_ctl_o, exp_ctl));
        if (m >= 3) begin
            exp_t = pt_q + `NCNT'(`NTI);
            exp_c = pc_q + `NCNT'(corr[m-3]);
            assert (prbs_total_o == exp_t) else
                fail_stop($sformatf("Fail prbs_total_o: got %h expected %h", prbs_total_o, exp_t));
            assert (prbs_correct_o == exp_c) else
                fail_stop($sformatf("Fail prbs_correct_o: got %h expected %h",
                                    prbs_correct_o, exp_c));
        end
        pc_q = prbs_correct_o;
        pt_q = prbs_total_o;
    endtask

    initial begin
        adc_word_t [`NTI-1:0] w;
        core_cfg_t            c;
        logic [`NCNT-1:0]     pc_q;
        logic [`NCNT-1:0]     pt_q;
        int                   m;
        int                   miss;
        int                   t;
        int                   v;
        bit                   b;

        void'($urandom(1));
        prbs_hist          = 7'h5a;
        cfg_init           = '0;
        cfg_init.pi_scale  = '1;
        cfg_i              = cfg_init;
        for (int i = 0; i < `NTI; i++) adc_i[i] = encode(0);

        rows[0] = '{1, 48, 1'b0, 1'b0, 0, 0, 0, 0};
        rows[1] = '{2, 40, 1'b0, 1'b0, 0, 0, 4, 12};
        rows[2] = '{1, 32, 1'b0, 1'b0, 110, 0, 0, -1};
        rows[3] = '{0, 12, 1'b0, 1'b1, 0, 0, 0, 0};
        rows[4] = '{0, 16, 1'b1, 1'b0, 0, 1, 0, 320};
        rows[5] = '{0, 16, 1'b1, 1'b0, 0, 0, 0, 0};

        t = 0;
        do begin
            @(negedge clk_adc);
            t++;
            if (t > 100) fail_stop("Timeout: reset was never released");
        end while (reset_i);

        assert (pi_ctl_o == '0 && prbs_correct_o == '0 && prbs_total_o == '0) else
            fail_stop($sformatf("Fail reset outputs: pi_ctl_o %h correct %h total %h",
                                pi_ctl_o, prbs_correct_o, prbs_total_o));
        pc_q = '0;
        pt_q = '0;
        m    = 0;

        foreach (rows[r]) begin
            c                = cfg_init;
            c.cdr_en         = rows[r].cdr_en;
            c.lane_offset[2] = sample_t'(rows[r].off2);
            if (rows[r].rnd_pi) begin
                for (int j = 0; j < `NOUT; j++) begin
                    c.pi_offset[j] = `NPI'($urandom);
                    c.pi_scale[j]  = `NPI'($urandom);
                end
            end
            if (rows[r].kind == 0) begin
                assert (pattern_err(rows[r].pat) == rows[r].exp) else
                    fail_stop($sformatf("Fail phase error: got %h expected %h",
                                        pattern_err(rows[r].pat), rows[r].exp));
            end
            miss = 0;
            for (int k = 0; k < rows[r].cycles; k++) begin
                for (int i = 0; i < `NTI; i++) begin
                    if (rows[r].kind == 0) begin
                        v = pat_val(rows[r].pat, i);
                    end else begin
                        b                = prbs_hist[6] ^ prbs_hist[5];
                        prbs_hist        = {prbs_hist[5:0], b};
                        v                = b ? 100 : -100;
                        if (rows[r].kind == 2 && k % 8 == 4 && k / 8 < rows[r].n_flip &&
                            i == (k / 8) % `NTI)
                            v = -v;
                    end
                    w[i] = encode(v);
                end
                @(posedge clk_adc);
                adc_i <= w;
                cfg_i <= c;
                record_word(m, w, c);
                if (rows[r].kind != 0 && k >= 2) miss = miss + `NTI - corr[m];
                @(negedge clk_adc);
                check_outputs(m, pc_q, pt_q);
                m++;
            end
            if (rows[r].kind != 0 && rows[r].exp >= 0) begin
                assert (miss == rows[r].exp) else
                    fail_stop($sformatf("Fail PRBS mismatches: got %h expected %h",
                                        miss, rows[r].exp));
            end else if (rows[r].kind != 0) begin
                assert (miss > 0) else
                    fail_stop("Lane offset did not cause any PRBS mismatch");
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

//--- hw/digital_core.sv
`timescale 1ns/1ps
`include "core_params.svh"

module digital_core (
    input  logic                           clk_adc,
    input  logic                           reset_i,
    input  core_pkg::adc_word_t [`NTI-1:0] adc_i,
    input  core_pkg::core_cfg_t            cfg_i,
    output core_pkg::pi_ctl_t              pi_ctl_o,
    output logic [`NCNT-1:0]               prbs_correct_o,
    output logic [`NCNT-1:0]               prbs_total_o
);
    import core_pkg::*;

    sample_t [`NTI-1:0] samples;
    logic [`NPI-1:0]    pi_code;

    // Unfold and de-offset each lane
    genvar k;
    generate
        for (k = 0; k < `NTI; k++) begin : g_lane
            adc_unfold u_unfold (
                .clk_adc  (clk_adc),
                .reset_i  (reset_i),
                .adc_i    (adc_i[k]),
                .offset_i (cfg_i.lane_offset[k]),
                .sample_o (samples[k])
            );
        end
    endgenerate

    mm_cdr u_cdr (
        .clk_adc    (clk_adc),
        .reset_i    (reset_i),
        .samples_i  (samples),
        .kp_shift_i (cfg_i.kp_shift),
        .cdr_en_i   (cfg_i.cdr_en),
        .pi_code_o  (pi_code)
    );

    pi_scaler u_scaler (
        .clk_adc     (clk_adc),
        .reset_i     (reset_i),
        .pi_code_i   (pi_code),
        .pi_offset_i (cfg_i.pi_offset),
        .pi_scale_i  (cfg_i.pi_scale),
        .pi_ctl_o    (pi_ctl_o)
    );

    // PRBS check on raw lane decisions
    prbs_checker u_prbs (
        .clk_adc   (clk_adc),
        .reset_i   (reset_i),
        .samples_i (samples),
        .correct_o (prbs_correct_o),
        .total_o   (prbs_total_o)
    );

endmodule

//--- hw/prbs_checker.sv
`timescale 1ns/1ps
`include "core_params.svh"

module prbs_checker (
    input  logic                         clk_adc,
    input  logic                         reset_i,
    input  core_pkg::sample_t [`NTI-1:0] samples_i,
    output logic [`NCNT-1:0]             correct_o,
    output logic [`NCNT-1:0]             total_o
);

    localparam int HIST   = `PRBS_TAP_A;
    localparam int FILL_W = $clog2(HIST + 1);

    logic [`NTI-1:0]      dec_q;
    logic                 dec_vld_q;
    logic [HIST-1:0]      hist_q;
    logic [FILL_W-1:0]    fill_q;
    logic [FILL_W-1:0]    fill_d;
    logic [`NTI+HIST-1:0] stream;
    logic [`NCNT-1:0]     n_correct;
    logic [`NCNT-1:0]     n_total;

    // Decision is 1 for zero or positive samples
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            dec_q     <= '0;
            dec_vld_q <= 1'b0;
        end else begin
            for (int i = 0; i < `NTI; i++) begin
                dec_q[i] <= ~samples_i[i][`NADC-1];
            end
            dec_vld_q <= 1'b1;
        end
    end

    // Oldest history bit at index 0, lane 0 right after the history
    assign stream = {dec_q, hist_q};

    always_comb begin
        n_correct = '0;
        n_total   = '0;
        for (int i = 0; i < `NTI; i++) begin
            // Only bits with a full history behind them
            if (int'(fill_q) + i >= HIST) begin
                n_total = n_total + 1'b1;
                if (stream[HIST+i] ==
                    (stream[HIST+i-`PRBS_TAP_A] ^ stream[HIST+i-`PRBS_TAP_B])) begin
                    n_correct = n_correct + 1'b1;
                end
            end
        end
    end

    assign fill_d = (int'(fill_q) + `NTI >= HIST) ? FILL_W'(HIST) : fill_q + FILL_W'(`NTI);

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            hist_q    <= '0;
            fill_q    <= '0;
            correct_o <= '0;
            total_o   <= '0;
        end else if (dec_vld_q) begin
            hist_q    <= stream[`NTI+HIST-1:`NTI];
            fill_q    <= fill_d;
            correct_o <= correct_o + n_correct;
            total_o   <= total_o + n_total;
        end
    end

    a_correct_le_total: assert property (@(posedge clk_adc) disable iff (reset_i)
        correct_o <= total_o);

endmodule

//--- hw/pi_scaler.sv
`timescale 1ns/1ps
`include "core_params.svh"

module pi_scaler (
    input  logic              clk_adc,
    input  logic              reset_i,
    input  logic [`NPI-1:0]   pi_code_i,
    input  core_pkg::pi_ctl_t pi_offset_i,
    input  core_pkg::pi_ctl_t pi_scale_i,
    output core_pkg::pi_ctl_t pi_ctl_o
);
    import core_pkg::*;

    logic [`NOUT-1:0][`NPI-1:0]   code_sum;
    logic [`NOUT-1:0][2*`NPI-1:0] product;
    pi_ctl_t                      ctl_d;

    genvar j;
    generate
        for (j = 0; j < `NOUT; j++) begin : g_out
            assign code_sum[j] = pi_code_i + pi_offset_i[j];
            assign product[j]  = code_sum[j] * pi_scale_i[j];
            assign ctl_d[j]    = product[j][2*`NPI-1:`NPI];

            // Full-scale gain lands within one LSB of the summed code
            a_unity_gain: assert property (@(posedge clk_adc) disable iff (reset_i)
                (pi_scale_i[j] == '1) |=>
                (pi_ctl_o[j] == $past(code_sum[j] -
                    {{(`NPI-1){1'b0}}, (code_sum[j] != '0)})));
        end
    endgenerate

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_ctl_o <= '0;
        end else begin
            pi_ctl_o <= ctl_d;
        end
    end

endmodule

//--- hw/mm_cdr.sv
`timescale 1ns/1ps
`include "core_params.svh"

module mm_cdr (
    input  logic                         clk_adc,
    input  logic                         reset_i,
    input  core_pkg::sample_t [`NTI-1:0] samples_i,
    input  logic [2:0]                   kp_shift_i,
    input  logic                         cdr_en_i,
    output logic [`NPI-1:0]              pi_code_o
);
    import core_pkg::*;

    // Headroom for the sum of NTI pair terms
    localparam int ERR_W = `NADC + 4;

    sample_t                 last_q;
    logic signed [ERR_W-1:0] err_sum;
    logic signed [ERR_W-1:0] pd_err_q;
    logic signed [ERR_W-1:0] err_shifted;

    // One Mueller-Muller pair term, zero counts as positive
    function automatic logic signed [ERR_W-1:0] mm_term(
        input sample_t prev,
        input sample_t cur
    );
        logic signed [ERR_W-1:0] p;
        logic signed [ERR_W-1:0] c;
        p = {{(ERR_W-`NADC){prev[`NADC-1]}}, prev};
        c = {{(ERR_W-`NADC){cur[`NADC-1]}}, cur};
        mm_term = (prev[`NADC-1] ? -c : c) - (cur[`NADC-1] ? -p : p);
    endfunction

    // Lane 0 pairs with the last lane of the previous word
    always_comb begin
        err_sum = mm_term(last_q, samples_i[0]);
        for (int i = 1; i < `NTI; i++) begin
            err_sum = err_sum + mm_term(samples_i[i-1], samples_i[i]);
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            last_q   <= '0;
            pd_err_q <= '0;
        end else begin
            last_q   <= samples_i[`NTI-1];
            pd_err_q <= err_sum;
        end
    end

    assign err_shifted = pd_err_q >>> kp_shift_i;

    // Accumulator wraps with the interpolator code
    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            pi_code_o <= '0;
        end else if (cdr_en_i) begin
            pi_code_o <= pi_code_o + err_shifted[`NPI-1:0];
        end
    end

    a_hold_when_disabled: assert property (@(posedge clk_adc) disable iff (reset_i)
        !cdr_en_i |=> $stable(pi_code_o));

endmodule

//--- hw/adc_unfold.sv
`timescale 1ns/1ps
`include "core_params.svh"

module adc_unfold (
    input  logic                clk_adc,
    input  logic                reset_i,
    input  core_pkg::adc_word_t adc_i,
    input  core_pkg::sample_t   offset_i,
    output core_pkg::sample_t   sample_o
);
    import core_pkg::*;

    localparam int W = `NADC + 2;
    localparam logic signed [W-1:0] LIM_HI = 2 ** (`NADC - 1) - 1;
    localparam logic signed [W-1:0] LIM_LO = -LIM_HI;

    logic signed [W-1:0] folded;
    logic signed [W-1:0] offset_ext;
    logic signed [W-1:0] diff;
    sample_t             sample_d;

    assign folded     = adc_i.sign ? $signed({2'b00, adc_i.mag}) : -$signed({2'b00, adc_i.mag});
    assign offset_ext = {{2{offset_i[`NADC-1]}}, offset_i};
    assign diff       = folded - offset_ext;

    // Symmetric clip keeps the code balanced around zero
    always_comb begin
        if (diff > LIM_HI) begin
            sample_d = LIM_HI[`NADC-1:0];
        end else if (diff < LIM_LO) begin
            sample_d = LIM_LO[`NADC-1:0];
        end else begin
            sample_d = diff[`NADC-1:0];
        end
    end

    always_ff @(posedge clk_adc) begin
        if (reset_i) begin
            sample_o <= '0;
        end else begin
            sample_o <= sample_d;
        end
    end

    a_no_min_code: assert property (@(posedge clk_adc) disable iff (reset_i)
        sample_o != {1'b1, {(`NADC-1){1'b0}}});

endmodule

//--- hw/core_pkg.sv
`include "core_params.svh"

package core_pkg;

    // Raw lane word, sign high means positive
    typedef struct packed {
        logic             sign;
        logic [`NADC-1:0] mag;
    } adc_word_t;

    typedef logic signed [`NADC-1:0] sample_t;

    typedef logic [`NOUT-1:0][`NPI-1:0] pi_ctl_t;

    typedef struct packed {
        sample_t [`NTI-1:0] lane_offset;
        pi_ctl_t            pi_offset;
        // All ones is unity gain
        pi_ctl_t            pi_scale;
        logic [2:0]         kp_shift;
        logic               cdr_en;
    } core_cfg_t;

endpackage

//--- hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Interleaving and datapath widths
`define NTI 4
`define NADC 8
`define NPI 9
`define NOUT 4

// PRBS checker counter width
`define NCNT 32

// PRBS7 feedback taps, in bit positions back
`define PRBS_TAP_A 7
`define PRBS_TAP_B 6

`endif
